//--- verilog/mc_pkg.sv
package mc_pkg;

	////////////////////////////////////////////////////////////
	// Widths and register map

	parameter int DATA_W = 32;
	parameter int MAX_CS = 8;

	// Register space select on addr[31:29]
	parameter logic [2:0] REG_SEL_VAL = 3'h3;

	// Word indices on addr[6:2]
	parameter logic [4:0] REG_IDX_CSR = 5'd0;
	parameter logic [4:0] REG_IDX_MASK = 5'd2;
	parameter logic [4:0] REG_IDX_CS_BASE = 5'd4;

	parameter logic [2:0] MEM_TYPE_SDRAM = 3'h0;
	parameter logic [DATA_W-1:0] TMS_RESET = '1;
	parameter logic [10:0] MASK_RESET = 11'h7ff;

	////////////////////////////////////////////////////////////
	// Field structs

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] addr;
		logic [DATA_W-1:0] data;
	} bus_req_t;

	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic [7:0] sel_base;
		logic [6:0] rsvd_mid;
		logic wp;
		logic [3:0] rsvd_lo;
		logic [2:0] mem_type;
		logic en;
	} csc_t;

	typedef struct packed {
		logic [7:0] rfr_ps_val;
		logic [12:0] rsvd_hi;
		logic [2:0] ref_int;
		logic [4:0] rsvd_lo;
		logic fs;
		logic vpen;
		logic sts;
	} csr_t;

	// Registered write strobe, data is live wb data
	typedef struct packed {
		logic we;
		logic [4:0] idx;
		logic [DATA_W-1:0] data;
	} reg_wr_t;

endpackage

//--- verilog/mc_reg_bus.sv
`timescale 1ns/10ps

module mc_reg_bus #(
	parameter int NUM_CS = 4
) (
	input  logic clk,
	input  logic rst,
	input  mc_pkg::bus_req_t bus_req_i,
	input  logic mc_sts_i,
	input  mc_pkg::csc_t [NUM_CS-1:0] csc_i,
	input  logic [NUM_CS-1:0][mc_pkg::DATA_W-1:0] tms_i,
	output logic ack_o,
	output logic [mc_pkg::DATA_W-1:0] rd_data_o,
	output mc_pkg::reg_wr_t reg_wr_o,
	output logic [10:0] csc_mask_o,
	output logic [2:0] ref_int_o,
	output logic [7:0] rfr_ps_val_o,
	output logic mc_vpen_o,
	output logic fs_o
);

	logic reg_sel;
	logic wr_we_q;
	logic [4:0] wr_idx_q;
	logic [4:0] rd_idx;
	logic [10:0] mask_q;
	mc_pkg::csr_t csr_q;
	mc_pkg::csr_t csr_wr;

	assign reg_sel = bus_req_i.cyc & bus_req_i.stb &
		(bus_req_i.addr[31:29] == mc_pkg::REG_SEL_VAL);

	////////////////////////////////////////////////////////////
	// Ack and write strobe

	// Held stb gives an ack every other cycle
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ack_o <= 1'b0;
			wr_we_q <= 1'b0;
		end
		else
		begin
			ack_o <= reg_sel & ~ack_o;
			wr_we_q <= reg_sel & bus_req_i.we & ~ack_o;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_idx_q <= bus_req_i.addr[6:2];
	end

	assign reg_wr_o = '{we: wr_we_q, idx: wr_idx_q, data: bus_req_i.data};
	assign csr_wr = reg_wr_o.data;

	////////////////////////////////////////////////////////////
	// Global registers

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			csr_q <= '0;
			mask_q <= mc_pkg::MASK_RESET;
		end
		else
		begin
			// Status bit tracks the controller every cycle
			csr_q.sts <= mc_sts_i;
			if (reg_wr_o.we && reg_wr_o.idx == mc_pkg::REG_IDX_CSR)
			begin
				csr_q.rfr_ps_val <= csr_wr.rfr_ps_val;
				csr_q.ref_int <= csr_wr.ref_int;
				csr_q.fs <= csr_wr.fs;
				csr_q.vpen <= csr_wr.vpen;
			end
			if (reg_wr_o.we && reg_wr_o.idx == mc_pkg::REG_IDX_MASK)
				mask_q <= reg_wr_o.data[10:0];
		end
	end

	assign csc_mask_o = mask_q;
	assign ref_int_o = csr_q.ref_int;
	assign rfr_ps_val_o = csr_q.rfr_ps_val;
	assign mc_vpen_o = csr_q.vpen;
	assign fs_o = csr_q.fs;

	////////////////////////////////////////////////////////////
	// Read back

	assign rd_idx = bus_req_i.addr[6:2];

	always_comb
	begin
		rd_data_o = '0;
		if (rd_idx == mc_pkg::REG_IDX_CSR)
			rd_data_o = csr_q;
		if (rd_idx == mc_pkg::REG_IDX_MASK)
			rd_data_o = {{(mc_pkg::DATA_W - 11){1'b0}}, mask_q};
		for (int i = 0; i < NUM_CS; i++)
		begin
			if (rd_idx == 5'(mc_pkg::REG_IDX_CS_BASE + 2 * i))
				rd_data_o = csc_i[i];
			if (rd_idx == 5'(mc_pkg::REG_IDX_CS_BASE + 2 * i + 1))
				rd_data_o = tms_i[i];
		end
	end

endmodule

//--- verilog/mc_cs_regs.sv
`timescale 1ns/10ps

module mc_cs_regs #(
	parameter int NUM_CS = 4,
	parameter int CS_IDX = 0
) (
	input  logic clk,
	input  logic rst,
	input  mc_pkg::bus_req_t bus_req_i,
	input  mc_pkg::reg_wr_t reg_wr_i,
	input  logic [10:0] csc_mask_i,
	input  logic [NUM_CS-1:0] init_ack_i,
	input  logic [NUM_CS-1:0] lmr_ack_i,
	output mc_pkg::csc_t csc_o,
	output logic [mc_pkg::DATA_W-1:0] tms_o,
	output logic match_o,
	output logic wp_err_o,
	output logic need_rfr_o,
	output logic init_pending_o,
	output logic lmr_pending_o
);

	localparam logic [4:0] CSC_IDX = 5'(mc_pkg::REG_IDX_CS_BASE + 2 * CS_IDX);
	localparam logic [4:0] TMS_IDX = CSC_IDX + 5'd1;

	mc_pkg::csc_t csc_wr;
	logic csc_we;
	logic tms_we;

	assign csc_wr = reg_wr_i.data;
	assign csc_we = reg_wr_i.we && reg_wr_i.idx == CSC_IDX;
	assign tms_we = reg_wr_i.we && reg_wr_i.idx == TMS_IDX;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			csc_o <= '0;
			tms_o <= mc_pkg::TMS_RESET;
			init_pending_o <= 1'b0;
			lmr_pending_o <= 1'b0;
		end
		else
		begin
			if (csc_we)
				csc_o <= csc_wr;
			if (tms_we)
				tms_o <= reg_wr_i.data;
			if (init_ack_i[CS_IDX])
				init_pending_o <= 1'b0;
			// New SDRAM config needs an init sequence
			if (csc_we && csc_wr.en && csc_wr.mem_type == mc_pkg::MEM_TYPE_SDRAM)
				init_pending_o <= 1'b1;
			if (lmr_ack_i[CS_IDX])
				lmr_pending_o <= 1'b0;
			if (tms_we && need_rfr_o)
				lmr_pending_o <= 1'b1;
		end
	end

	// Masked compare of base against addr[28:21]
	assign match_o = csc_o.en &&
		(((csc_o.sel_base ^ bus_req_i.addr[28:21]) & csc_mask_i[7:0]) == 8'h00);
	assign wp_err_o = match_o & bus_req_i.we & csc_o.wp;
	assign need_rfr_o = csc_o.en && csc_o.mem_type == mc_pkg::MEM_TYPE_SDRAM;

endmodule

//--- verilog/mc_cs_decode.sv
`timescale 1ns/10ps

module mc_cs_decode #(
	parameter int NUM_CS = 4
) (
	input  logic clk,
	input  logic rst,
	input  mc_pkg::bus_req_t bus_req_i,
	input  logic cs_le_i,
	input  logic [NUM_CS-1:0] match_i,
	input  logic [NUM_CS-1:0] wp_i,
	input  mc_pkg::csc_t [NUM_CS-1:0] csc_i,
	input  logic [NUM_CS-1:0][mc_pkg::DATA_W-1:0] tms_i,
	output logic [mc_pkg::MAX_CS-1:0] cs_o,
	output logic wp_err_o,
	output logic [mc_pkg::DATA_W-1:0] csc_sel_o,
	output logic [mc_pkg::DATA_W-1:0] tms_sel_o
);

	logic load;
	logic [mc_pkg::MAX_CS-1:0] cs_d;
	logic [mc_pkg::DATA_W-1:0] csc_d;
	logic [mc_pkg::DATA_W-1:0] tms_d;

	assign load = cs_le_i & bus_req_i.cyc & bus_req_i.stb;

	// Lowest match wins, last slot when nothing matches
	always_comb
	begin
		cs_d = '0;
		cs_d[NUM_CS-1:0] = match_i;
		csc_d = csc_i[NUM_CS-1];
		tms_d = tms_i[NUM_CS-1];
		for (int i = NUM_CS - 1; i >= 0; i--)
		begin
			if (match_i[i])
			begin
				csc_d = csc_i[i];
				tms_d = tms_i[i];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cs_o <= '0;
			wp_err_o <= 1'b0;
			csc_sel_o <= '0;
			tms_sel_o <= mc_pkg::TMS_RESET;
		end
		else if (load)
		begin
			cs_o <= cs_d;
			wp_err_o <= |wp_i;
			csc_sel_o <= csc_d;
			tms_sel_o <= tms_d;
		end
		else if (!bus_req_i.cyc)
			wp_err_o <= 1'b0;
	end

endmodule

//--- verilog/mc_spec_req_fsm.sv
`timescale 1ns/10ps

module mc_spec_req_fsm #(
	parameter int NUM_CS = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [NUM_CS-1:0] init_pending_i,
	input  logic [NUM_CS-1:0] lmr_pending_i,
	input  logic init_ack_i,
	input  logic lmr_ack_i,
	output logic init_req_o,
	output logic lmr_req_o,
	output logic [mc_pkg::MAX_CS-1:0] spec_req_cs_o,
	output logic [NUM_CS-1:0] init_done_o,
	output logic [NUM_CS-1:0] lmr_done_o
);

	typedef enum logic [1:0] {IDLE, INIT, LMR} state_t;

	state_t state_q;
	logic init_ack_q;
	logic lmr_ack_q;
	logic init_ack_fe;
	logic lmr_ack_fe;
	logic done_busy;
	logic [NUM_CS-1:0] init_first;
	logic [NUM_CS-1:0] lmr_first;
	logic [NUM_CS-1:0] grant_q;

	assign init_ack_fe = init_ack_q & ~init_ack_i;
	assign lmr_ack_fe = lmr_ack_q & ~lmr_ack_i;

	// Isolate lowest set bit
	assign init_first = init_pending_i & (~init_pending_i + 1'b1);
	assign lmr_first = lmr_pending_i & (~lmr_pending_i + 1'b1);

	// Pending flag of the finished slot is still up while done is out
	assign done_busy = (|init_done_o) | (|lmr_done_o);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state_q <= IDLE;
			grant_q <= '0;
			init_ack_q <= 1'b0;
			lmr_ack_q <= 1'b0;
			init_req_o <= 1'b0;
			lmr_req_o <= 1'b0;
			init_done_o <= '0;
			lmr_done_o <= '0;
		end
		else
		begin
			init_ack_q <= init_ack_i;
			lmr_ack_q <= lmr_ack_i;
			init_done_o <= '0;
			lmr_done_o <= '0;
			case (state_q)
				IDLE:
				begin
					if (!done_busy && |init_pending_i)
					begin
						state_q <= INIT;
						grant_q <= init_first;
						init_req_o <= 1'b1;
					end
					else if (!done_busy && |lmr_pending_i)
					begin
						state_q <= LMR;
						grant_q <= lmr_first;
						lmr_req_o <= 1'b1;
					end
				end
				INIT:
				begin
					if (init_ack_fe)
					begin
						state_q <= IDLE;
						init_req_o <= 1'b0;
						init_done_o <= grant_q;
						grant_q <= '0;
					end
				end
				LMR:
				begin
					if (lmr_ack_fe)
					begin
						state_q <= IDLE;
						lmr_req_o <= 1'b0;
						lmr_done_o <= grant_q;
						grant_q <= '0;
					end
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	always_comb
	begin
		spec_req_cs_o = '0;
		spec_req_cs_o[NUM_CS-1:0] = grant_q;
	end

endmodule

//--- verilog/mc_rf_top.sv
`timescale 1ns/10ps

module mc_rf_top #(
	parameter int NUM_CS = 4
) (
	input  logic clk,
	input  logic rst,
	input  mc_pkg::bus_req_t bus_req_i,
	input  logic mc_sts_i,
	input  logic cs_le_i,
	input  logic init_ack_i,
	input  logic lmr_ack_i,
	output logic ack_o,
	output logic [mc_pkg::DATA_W-1:0] rd_data_o,
	output logic wp_err_o,
	output logic [mc_pkg::MAX_CS-1:0] cs_o,
	output logic [mc_pkg::DATA_W-1:0] csc_sel_o,
	output logic [mc_pkg::DATA_W-1:0] tms_sel_o,
	output logic [mc_pkg::MAX_CS-1:0] cs_need_rfr_o,
	output logic [2:0] ref_int_o,
	output logic [7:0] rfr_ps_val_o,
	output logic mc_vpen_o,
	output logic fs_o,
	output logic init_req_o,
	output logic lmr_req_o,
	output logic [mc_pkg::MAX_CS-1:0] spec_req_cs_o
);

	mc_pkg::reg_wr_t reg_wr;
	logic [10:0] csc_mask;
	mc_pkg::csc_t [NUM_CS-1:0] csc;
	logic [NUM_CS-1:0][mc_pkg::DATA_W-1:0] tms;
	logic [NUM_CS-1:0] match;
	logic [NUM_CS-1:0] wp;
	logic [NUM_CS-1:0] init_pending;
	logic [NUM_CS-1:0] lmr_pending;
	logic [NUM_CS-1:0] init_done;
	logic [NUM_CS-1:0] lmr_done;

	mc_reg_bus #(.NUM_CS(NUM_CS)) u_reg_bus (
		.clk(clk),
		.rst(rst),
		.bus_req_i(bus_req_i),
		.mc_sts_i(mc_sts_i),
		.csc_i(csc),
		.tms_i(tms),
		.ack_o(ack_o),
		.rd_data_o(rd_data_o),
		.reg_wr_o(reg_wr),
		.csc_mask_o(csc_mask),
		.ref_int_o(ref_int_o),
		.rfr_ps_val_o(rfr_ps_val_o),
		.mc_vpen_o(mc_vpen_o),
		.fs_o(fs_o)
	);

	////////////////////////////////////////////////////////////
	// Chip select register slots, refresh bits padded to MAX_CS

	for (genvar i = 0; i < mc_pkg::MAX_CS; i++)
	begin : g_cs
		if (i < NUM_CS)
		begin : g_slot
			mc_cs_regs #(.NUM_CS(NUM_CS), .CS_IDX(i)) u_cs_regs (
				.clk(clk),
				.rst(rst),
				.bus_req_i(bus_req_i),
				.reg_wr_i(reg_wr),
				.csc_mask_i(csc_mask),
				.init_ack_i(init_done),
				.lmr_ack_i(lmr_done),
				.csc_o(csc[i]),
				.tms_o(tms[i]),
				.match_o(match[i]),
				.wp_err_o(wp[i]),
				.need_rfr_o(cs_need_rfr_o[i]),
				.init_pending_o(init_pending[i]),
				.lmr_pending_o(lmr_pending[i])
			);
		end
		else
		begin : g_absent
			assign cs_need_rfr_o[i] = 1'b0;
		end
	end

	mc_cs_decode #(.NUM_CS(NUM_CS)) u_cs_decode (
		.clk(clk),
		.rst(rst),
		.bus_req_i(bus_req_i),
		.cs_le_i(cs_le_i),
		.match_i(match),
		.wp_i(wp),
		.csc_i(csc),
		.tms_i(tms),
		.cs_o(cs_o),
		.wp_err_o(wp_err_o),
		.csc_sel_o(csc_sel_o),
		.tms_sel_o(tms_sel_o)
	);

	mc_spec_req_fsm #(.NUM_CS(NUM_CS)) u_spec_req_fsm (
		.clk(clk),
		.rst(rst),
		.init_pending_i(init_pending),
		.lmr_pending_i(lmr_pending),
		.init_ack_i(init_ack_i),
		.lmr_ack_i(lmr_ack_i),
		.init_req_o(init_req_o),
		.lmr_req_o(lmr_req_o),
		.spec_req_cs_o(spec_req_cs_o),
		.init_done_o(init_done),
		.lmr_done_o(lmr_done)
	);

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RST_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Release a little after the edge
	initial
	begin
		rst_o = 1'b1;
		repeat (RST_CYCLES)
			@(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

//--- dv/mc_rf_tb.sv
`timescale 1ns/10ps

module mc_rf_tb;

	localparam int NUM_CS = 4;
	localparam int TEST_CYCLES = 600;
	localparam int CYCLE_LIMIT = 3 * TEST_CYCLES + 200;
	localparam int ACK_WAIT = 16;
	localparam int REQ_WAIT = 32;
	// Writable CSR fields
	localparam logic [31:0] CSR_RW = 32'hff00_0706;

	logic clk;
	logic rst;
	mc_pkg::bus_req_t bus_req;
	logic mc_sts;
	logic cs_le;
	logic init_ack;
	logic lmr_ack;
	logic ack_o;
	logic [31:0] rd_data_o;
	logic wp_err_o;
	logic [7:0] cs_o;
	logic [31:0] csc_sel_o;
	logic [31:0] tms_sel_o;
	logic [7:0] cs_need_rfr_o;
	logic [2:0] ref_int_o;
	logic [7:0] rfr_ps_val_o;
	logic mc_vpen_o;
	logic fs_o;
	logic init_req_o;
	logic lmr_req_o;
	logic [7:0] spec_req_cs_o;

	integer seed = 32'h9e1b0c22;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;
	int cycles = 0;
	string test_name;
	mc_pkg::csr_t shadow_csr;
	logic [10:0] shadow_mask;
	mc_pkg::csc_t shadow_csc [NUM_CS];
	logic [31:0] shadow_tms [NUM_CS];
	logic [7:0] rfr_exp;

	tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

	mc_rf_top #(.NUM_CS(NUM_CS)) uut (
		.clk(clk),
		.rst(rst),
		.bus_req_i(bus_req),
		.mc_sts_i(mc_sts),
		.cs_le_i(cs_le),
		.init_ack_i(init_ack),
		.lmr_ack_i(lmr_ack),
		.ack_o(ack_o),
		.rd_data_o(rd_data_o),
		.wp_err_o(wp_err_o),
		.cs_o(cs_o),
		.csc_sel_o(csc_sel_o),
		.tms_sel_o(tms_sel_o),
		.cs_need_rfr_o(cs_need_rfr_o),
		.ref_int_o(ref_int_o),
		.rfr_ps_val_o(rfr_ps_val_o),
		.mc_vpen_o(mc_vpen_o),
		.fs_o(fs_o),
		.init_req_o(init_req_o),
		.lmr_req_o(lmr_req_o),
		.spec_req_cs_o(spec_req_cs_o)
	);

	// Enabled SDRAM slots need refresh
	always_comb
	begin
		rfr_exp = '0;
		for (int n = 0; n < NUM_CS; n++)
			rfr_exp[n] = shadow_csc[n].en && shadow_csc[n].mem_type == mc_pkg::MEM_TYPE_SDRAM;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
		errors++;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			fail_value(name, got, exp);
	endtask

	////////////////////////////////////////////////////////////
	// Concurrent checks, sampled mid-cycle

	assert property (@(negedge clk) disable iff (rst) ack_o |=> !ack_o)
	else
	begin
		$display("ack_o stayed high for more than one cycle at %0t", $time);
		errors++;
	end

	assert property (@(negedge clk) disable iff (rst)
		(init_req_o || lmr_req_o) |-> $onehot(spec_req_cs_o) && !(init_req_o && lmr_req_o))
	else
	begin
		$display("request select is not one-hot while a request is up at %0t", $time);
		errors++;
	end

	assert property (@(negedge clk) disable iff (rst)
		{rfr_ps_val_o, ref_int_o, fs_o, mc_vpen_o} ==
		{shadow_csr.rfr_ps_val, shadow_csr.ref_int, shadow_csr.fs, shadow_csr.vpen})
	else
		fail_value("csr field outputs", {rfr_ps_val_o, ref_int_o, fs_o, mc_vpen_o},
			{shadow_csr.rfr_ps_val, shadow_csr.ref_int, shadow_csr.fs, shadow_csr.vpen});

	assert property (@(negedge clk) disable iff (rst) cs_need_rfr_o == rfr_exp)
	else
		fail_value("cs_need_rfr_o", cs_need_rfr_o, rfr_exp);

	////////////////////////////////////////////////////////////
	// Bus and shadow model

	function automatic logic [31:0] reg_addr(input logic [4:0] idx);
		return {mc_pkg::REG_SEL_VAL, 22'h0, idx, 2'b00};
	endfunction

	function automatic logic [4:0] cs_reg_index(input int slot, input int is_tms);
		return 5'(mc_pkg::REG_IDX_CS_BASE + 2 * slot + is_tms);
	endfunction

	function automatic logic [31:0] expected_read(input logic [4:0] idx);
		logic [31:0] value;
		int slot;
		value = '0;
		slot = (int'(idx) - int'(mc_pkg::REG_IDX_CS_BASE)) / 2;
		if (idx == mc_pkg::REG_IDX_CSR)
			value = shadow_csr | {31'h0, mc_sts};
		else if (idx == mc_pkg::REG_IDX_MASK)
			value = {21'h0, shadow_mask};
		else if (idx >= mc_pkg::REG_IDX_CS_BASE && slot < NUM_CS)
			value = idx[0] ? shadow_tms[slot] : shadow_csc[slot];
		return value;
	endfunction

	task automatic bus_access(input logic we, input logic [4:0] idx, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int wait_cycles;
		logic ack_seen;
		@(posedge clk);
		#1;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = we;
		bus_req.addr = reg_addr(idx);
		bus_req.data = wdata;
		wait_cycles = 0;
		ack_seen = 1'b0;
		while (!ack_seen && wait_cycles < ACK_WAIT)
		begin
			@(posedge clk);
			#1;
			wait_cycles++;
			ack_seen = ack_o;
		end
		if (!ack_seen)
		begin
			$display("no ack for the access to index %0d at %0t", idx, $time);
			errors++;
		end
		rdata = rd_data_o;
		// Write data stays valid through the ack cycle
		@(posedge clk);
		#1;
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we = 1'b0;
	endtask

	task automatic bus_write(input logic [4:0] idx, input logic [31:0] data);
		logic [31:0] unused;
		int slot;
		bus_access(1'b1, idx, data, unused);
		slot = (int'(idx) - int'(mc_pkg::REG_IDX_CS_BASE)) / 2;
		if (idx == mc_pkg::REG_IDX_CSR)
			shadow_csr = data & CSR_RW;
		else if (idx == mc_pkg::REG_IDX_MASK)
			shadow_mask = data[10:0];
		else if (idx >= mc_pkg::REG_IDX_CS_BASE && slot < NUM_CS && idx[0])
			shadow_tms[slot] = data;
		else if (idx >= mc_pkg::REG_IDX_CS_BASE && slot < NUM_CS)
			shadow_csc[slot] = data;
	endtask

	task automatic read_check(input logic [4:0] idx);
		logic [31:0] rdata;
		bus_access(1'b0, idx, 32'h0, rdata);
		check_eq($sformatf("rd_data_o idx %0d", idx), rdata, expected_read(idx));
	endtask

	task automatic read_all();
		int unmapped [6];
		unmapped = '{1, 3, 12, 15, 20, 31};
		read_check(mc_pkg::REG_IDX_CSR);
		read_check(mc_pkg::REG_IDX_MASK);
		for (int n = 0; n < 2 * NUM_CS; n++)
			read_check(5'(mc_pkg::REG_IDX_CS_BASE + n));
		foreach (unmapped[i])
			read_check(5'(unmapped[i]));
	endtask

	////////////////////////////////////////////////////////////
	// Memory side stimulus

	task automatic mem_access(input logic [7:0] base, input logic we);
		@(posedge clk);
		#1;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = we;
		bus_req.addr = {3'b000, base, 21'h0};
		bus_req.data = 32'h0;
		cs_le = 1'b1;
		@(posedge clk);
		#1;
		cs_le = 1'b0;
	endtask

	task automatic mem_release();
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we = 1'b0;
		@(posedge clk);
		#1;
		check_eq("wp_err_o", wp_err_o, 1'b0);
	endtask

	task automatic serve_grant(input logic is_init, input int slot);
		int wait_cycles;
		wait_cycles = 0;
		while (!(init_req_o || lmr_req_o) && wait_cycles < REQ_WAIT)
		begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end
		if (!(init_req_o || lmr_req_o))
		begin
			$display("no request came for chip select %0d at %0t", slot, $time);
			errors++;
		end
		else
		begin
			check_eq("init_req_o", init_req_o, is_init);
			check_eq("lmr_req_o", lmr_req_o, !is_init);
			check_eq("spec_req_cs_o", spec_req_cs_o, 32'(1 << slot));
			init_ack = is_init;
			lmr_ack = !is_init;
			repeat (2)
			begin
				@(posedge clk);
				#1;
				check_eq("request during ack", init_req_o | lmr_req_o, 1'b1);
			end
			init_ack = 1'b0;
			lmr_ack = 1'b0;
			wait_cycles = 0;
			while ((init_req_o || lmr_req_o) && wait_cycles < REQ_WAIT)
			begin
				@(posedge clk);
				#1;
				wait_cycles++;
			end
			if (init_req_o || lmr_req_o)
			begin
				$display("request for chip select %0d not withdrawn after ack", slot);
				errors++;
			end
		end
	endtask

	task automatic test_start(input string name);
		test_name = name;
		test_err_base = errors;
	endtask

	task automatic test_end();
		tests_run++;
		if (errors == test_err_base)
			$display("test %0d %s: pass", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", tests_run, test_name, errors - test_err_base);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		bus_req = '0;
		mc_sts = 1'b0;
		cs_le = 1'b0;
		init_ack = 1'b0;
		lmr_ack = 1'b0;
		shadow_csr = '0;
		shadow_mask = mc_pkg::MASK_RESET;
		for (int n = 0; n < NUM_CS; n++)
		begin
			shadow_csc[n] = '0;
			shadow_tms[n] = mc_pkg::TMS_RESET;
		end
		@(negedge rst);

		test_start("reset values and readback");
		read_all();
		mc_sts = 1'b1;
		bus_write(mc_pkg::REG_IDX_CSR, $random(seed));
		bus_write(mc_pkg::REG_IDX_MASK, $random(seed));
		// Enable kept low so no init request starts
		for (int n = 0; n < NUM_CS; n++)
		begin
			bus_write(cs_reg_index(n, 0), $random(seed) & ~32'h1);
			bus_write(cs_reg_index(n, 1), $random(seed));
		end
		read_all();
		test_end();

		test_start("csr fields to outputs");
		for (int i = 0; i < 3; i++)
		begin
			bus_write(mc_pkg::REG_IDX_CSR, $random(seed));
			check_eq("ref_int_o", ref_int_o, shadow_csr.ref_int);
			check_eq("rfr_ps_val_o", rfr_ps_val_o, shadow_csr.rfr_ps_val);
			check_eq("mc_vpen_o", mc_vpen_o, shadow_csr.vpen);
			check_eq("fs_o", fs_o, shadow_csr.fs);
		end
		test_end();

		test_start("chip select decode");
		bus_write(mc_pkg::REG_IDX_MASK, 32'h0000_07f0);
		for (int n = 0; n < NUM_CS; n++)
			bus_write(cs_reg_index(n, 0),
				{8'h00, 4'(n + 1), 4'h5, 7'h00, 1'(n == 2), 4'h0, 3'h2, 1'b1});
		for (int n = 0; n < NUM_CS; n++)
		begin
			mem_access({4'(n + 1), 4'($random(seed))}, 1'b0);
			check_eq("cs_o", cs_o, 32'(1 << n));
			check_eq("csc_sel_o", csc_sel_o, shadow_csc[n]);
			check_eq("tms_sel_o", tms_sel_o, shadow_tms[n]);
			check_eq("wp_err_o", wp_err_o, 1'b0);
			mem_release();
		end
		mem_access(8'h95, 1'b0);
		check_eq("cs_o", cs_o, 32'h0);
		mem_release();
		mem_access(8'h3a, 1'b1);
		check_eq("wp_err_o", wp_err_o, 1'b1);
		mem_release();
		mem_access(8'h2c, 1'b1);
		check_eq("wp_err_o", wp_err_o, 1'b0);
		mem_release();
		test_end();

		test_start("refresh need");
		bus_write(cs_reg_index(3, 0), 32'h0);
		check_eq("cs_need_rfr_o", cs_need_rfr_o, 8'h00);
		// Starts an init grant on chip select 0
		bus_write(cs_reg_index(0, 0), {8'h00, 8'h15, 12'h000, mc_pkg::MEM_TYPE_SDRAM, 1'b1});
		check_eq("cs_need_rfr_o", cs_need_rfr_o, 8'h01);
		test_end();

		test_start("init and lmr arbitration");
		bus_write(cs_reg_index(2, 0), {8'h00, 8'h35, 12'h000, mc_pkg::MEM_TYPE_SDRAM, 1'b1});
		bus_write(cs_reg_index(1, 0), {8'h00, 8'h25, 12'h000, mc_pkg::MEM_TYPE_SDRAM, 1'b1});
		bus_write(cs_reg_index(0, 1), $random(seed));
		check_eq("cs_need_rfr_o", cs_need_rfr_o, 8'h07);
		serve_grant(1'b1, 0);
		serve_grant(1'b1, 1);
		serve_grant(1'b1, 2);
		serve_grant(1'b0, 0);
		repeat (4)
			@(posedge clk);
		#1;
		check_eq("request after queue drained", init_req_o | lmr_req_o, 1'b0);
		test_end();

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- list.f
verilog/mc_pkg.sv
verilog/mc_reg_bus.sv
verilog/mc_cs_regs.sv
verilog/mc_cs_decode.sv
verilog/mc_spec_req_fsm.sv
verilog/mc_rf_top.sv
dv/tb_clk_gen.sv
dv/mc_rf_tb.sv

//--- Bender.yml
package:
  name: mc_rf

sources:
  - verilog/mc_pkg.sv
  - verilog/mc_reg_bus.sv
  - verilog/mc_cs_regs.sv
  - verilog/mc_cs_decode.sv
  - verilog/mc_spec_req_fsm.sv
  - verilog/mc_rf_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/mc_rf_tb.sv
